//--- mips_mmu.f
hw/mmu_pkg.sv
hw/cp0.sv
hw/tlb_entry.sv
hw/tlb_ctrl.sv
hw/tlb_match_sel.sv
hw/mmu_top.sv
sim/mmu_assertions.sv
sim/tb_mmu_top.sv

//--- Bender.yml
package:
  name: mips_mmu

sources:
  - hw/mmu_pkg.sv
  - hw/cp0.sv
  - hw/tlb_entry.sv
  - hw/tlb_ctrl.sv
  - hw/tlb_match_sel.sv
  - hw/mmu_top.sv
  - target: simulation
    files:
      - sim/mmu_assertions.sv
      - sim/tb_mmu_top.sv

//--- sim/tb_mmu_top.sv
module tb_mmu_top import mmu_pkg::*; ();

    localparam int TLB_ENTRIES  = 16;
    localparam int RESET_CYCLES = 10;
    // Cycle budgets of the tests plus a margin
    localparam int LIMIT = RESET_CYCLES + 40 + 80 + 20 + 20 + 60 + 60 + 40;
    localparam int SLOTS [4] = '{2, 7, 11, 13};
    localparam logic [3:0] G0_SET = 4'b1010;
    localparam logic [3:0] G1_SET = 4'b0010;
    localparam logic [3:0] V0_SET = 4'b1011;

    logic          clk = 1'b0;
    logic          rst;
    logic          mfc0_ena;
    cp0_reg_e      mfc0_addr;
    logic [31:0]   mfc0_data;
    logic          mtc0_ena;
    cp0_reg_e      mtc0_addr;
    logic [31:0]   mtc0_data;
    logic          exc_ena;
    exc_update_t   exc;
    logic          eret;
    logic [5:0]    interrupt;
    logic          has_int;
    tlb_op_e       tlb_op;
    logic          lookup_ena;
    logic [31:0]   vaddr;
    logic          lookup_valid;
    xlate_result_t result;
    logic [31:0]   epc;

    int          errors;
    int          cycles = 0;
    logic [31:0] lfsr;
    logic [7:0]  asid_a;
    tlb_entry_t  model_tlb [TLB_ENTRIES];

    mmu_top #(.TLB_ENTRIES(TLB_ENTRIES)) i_mmu_top (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic [2:0] c,
                                            input logic d, input logic v, input logic g);
        return {6'h0, pfn, c, d, v, g};
    endfunction

    function automatic xlate_result_t expected_xlate(input logic [31:0] va,
                                                     input logic [7:0] asid);
        xlate_result_t r;
        tlb_entry_t    e;
        r      = '0;
        r.miss = 1'b1;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            e = model_tlb[i];
            if (r.miss && e.vpn2 == va[31:13] && (e.g || e.asid == asid)) begin
                r.miss    = 1'b0;
                r.paddr   = {va[12] ? e.pfn1 : e.pfn0, va[11:0]};
                r.invalid = va[12] ? !e.v1 : !e.v0;
                r.dirty   = va[12] ? e.d1 : e.d0;
                r.cache   = va[12] ? e.c1 : e.c0;
            end
        end
        return r;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // A miss carries no page data
    task automatic check_result(input string name, input xlate_result_t got,
                                input xlate_result_t exp);
        if (exp.miss ? (got.miss !== 1'b1 || got.invalid !== 1'b0) : (got !== exp)) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic clear_strobes();
        mfc0_ena   = 1'b0;
        mtc0_ena   = 1'b0;
        exc_ena    = 1'b0;
        eret       = 1'b0;
        tlb_op     = TLB_NONE;
        lookup_ena = 1'b0;
    endtask

    task automatic write_reg(input cp0_reg_e addr, input logic [31:0] data);
        @(negedge clk);
        clear_strobes();
        mtc0_ena  = 1'b1;
        mtc0_addr = addr;
        mtc0_data = data;
    endtask

    task automatic read_reg(input cp0_reg_e addr, output logic [31:0] data);
        @(negedge clk);
        clear_strobes();
        mfc0_ena  = 1'b1;
        mfc0_addr = addr;
        #1;
        data = mfc0_data;
    endtask

    task automatic read_check(input string name, input cp0_reg_e addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        read_reg(addr, rd);
        check_word(name, rd, exp);
    endtask

    task automatic write_read(input string name, input cp0_reg_e addr,
                              input logic [31:0] data, input logic [31:0] exp);
        write_reg(addr, data);
        read_check(name, addr, exp);
    endtask

    task automatic tlb_cmd(input tlb_op_e op);
        @(negedge clk);
        clear_strobes();
        tlb_op = op;
    endtask

    task automatic write_slot(input int slot, input logic [31:0] hi,
                              input logic [31:0] lo0, input logic [31:0] lo1);
        write_reg(ENTRYHI, hi);
        write_reg(ENTRYLO0, lo0);
        write_reg(ENTRYLO1, lo1);
        write_reg(INDEX, 32'(slot));
        tlb_cmd(TLB_WI);
        // EntryLo bits 25:1 hold PFN, C, D and V
        model_tlb[slot] = {hi[31:13], hi[7:0], lo0[0] & lo1[0], lo0[25:1], lo1[25:1]};
    endtask

    task automatic probe_check(input logic [31:0] hi, input logic [31:0] exp);
        write_reg(ENTRYHI, hi);
        tlb_cmd(TLB_P);
        read_check("index after tlbp", INDEX, exp);
    endtask

    task automatic int_check(input logic [31:0] status, input logic [5:0] irq,
                             input logic exp);
        write_reg(STATUS, status);
        interrupt = irq;
        @(negedge clk);
        clear_strobes();
        #1;
        check_bit("has_int", has_int, exp);
    endtask

    task automatic register_access();
        logic [31:0] d;
        read_check("status reset", STATUS, STATUS_RESET);
        read_check("config reset", CONFIG, CONFIG_RESET);
        read_check("config1 reset", CONFIG1, CONFIG1_RESET);
        d = random_bits(32);
        write_read("index", INDEX, d, d & 32'(TLB_ENTRIES - 1));
        d = random_bits(32);
        write_read("entrylo0", ENTRYLO0, d, d & 32'h03ff_ffff);
        d = random_bits(32);
        write_read("entrylo1", ENTRYLO1, d, d & 32'h03ff_ffff);
        d = random_bits(32);
        write_read("entryhi", ENTRYHI, d, d & 32'hffff_e0ff);
        d = random_bits(32);
        write_read("count", COUNT, d, d);
        d = random_bits(32);
        write_read("compare", COMPARE, d, d);
        d = random_bits(32);
        write_read("status", STATUS, d, STATUS_RESET | (d & 32'h0000_ff03));
        d = random_bits(32);
        write_read("cause", CAUSE, d, d & 32'h0000_0300);
        d = random_bits(32);
        write_read("epc", EPC, d, d);
        d = random_bits(32);
        write_read("config", CONFIG, d, (CONFIG_RESET & ~32'h7) | (d & 32'h7));
        d = random_bits(32);
        @(negedge clk);
        clear_strobes();
        mtc0_ena  = 1'b1;
        mtc0_addr = EPC;
        mtc0_data = d;
        mfc0_ena  = 1'b1;
        mfc0_addr = EPC;
        #1;
        check_word("mfc0 bypass", mfc0_data, d);
        @(negedge clk);
        clear_strobes();
        #1;
        check_word("mfc0 disabled", mfc0_data, 32'h0);
        @(negedge clk);
        mfc0_ena  = 1'b1;
        mfc0_addr = cp0_reg_e'(8'h08);
        #1;
        check_word("mfc0 unlisted", mfc0_data, 32'h0);
    endtask

    task automatic tlb_write_read();
        logic [18:0] vpn2;
        logic [31:0] lo0;
        logic [31:0] lo1;
        tlb_entry_t  m;
        asid_a = 8'(random_bits(8));
        for (int i = 0; i < 4; i++) begin
            vpn2 = {15'(random_bits(15)), 4'(SLOTS[i])};
            lo0  = make_lo(20'(random_bits(20)), 3'(random_bits(3)), 1'(random_bits(1)),
                           V0_SET[i], G0_SET[i]);
            lo1  = make_lo(20'(random_bits(20)), 3'(random_bits(3)), 1'(random_bits(1)),
                           1'b1, G1_SET[i]);
            write_slot(SLOTS[i], {vpn2, 5'(random_bits(5)), asid_a}, lo0, lo1);
        end
        for (int i = 0; i < 4; i++) begin
            m = model_tlb[SLOTS[i]];
            write_reg(ENTRYHI, 32'h0);
            write_reg(ENTRYLO0, 32'h0);
            write_reg(ENTRYLO1, 32'h0);
            write_reg(INDEX, 32'(SLOTS[i]));
            tlb_cmd(TLB_R);
            read_check("entryhi after tlbr", ENTRYHI, {m.vpn2, 5'h0, m.asid});
            read_check("entrylo0 after tlbr", ENTRYLO0, make_lo(m.pfn0, m.c0, m.d0, m.v0, m.g));
            read_check("entrylo1 after tlbr", ENTRYLO1, make_lo(m.pfn1, m.c1, m.d1, m.v1, m.g));
        end
    endtask

    task automatic tlb_probe();
        probe_check({model_tlb[SLOTS[0]].vpn2, 5'h0, asid_a}, 32'(SLOTS[0]));
        // Global entry hits under any ASID
        probe_check({model_tlb[SLOTS[1]].vpn2, 5'h0, asid_a ^ 8'h5a}, 32'(SLOTS[1]));
        probe_check({model_tlb[SLOTS[3]].vpn2, 5'h0, asid_a ^ 8'h5a}, 32'h8000_0000);
        probe_check({15'(random_bits(15)), 4'hf, 5'h0, asid_a}, 32'h8000_0000);
    endtask

    task automatic translation();
        logic [31:0]   va [7];
        xlate_result_t exp [7];
        write_reg(ENTRYHI, {24'h0, asid_a});
        va[0] = {model_tlb[SLOTS[0]].vpn2, 1'b0, 12'(random_bits(12))};
        va[1] = {model_tlb[SLOTS[0]].vpn2, 1'b1, 12'(random_bits(12))};
        va[2] = {model_tlb[SLOTS[1]].vpn2, 1'b1, 12'(random_bits(12))};
        va[3] = {15'(random_bits(15)), 4'hf, 13'(random_bits(13))};
        va[4] = {model_tlb[SLOTS[2]].vpn2, 1'b0, 12'(random_bits(12))};
        va[5] = {model_tlb[SLOTS[2]].vpn2, 1'b1, 12'(random_bits(12))};
        va[6] = {model_tlb[SLOTS[3]].vpn2, 1'b1, 12'(random_bits(12))};
        for (int i = 0; i < 7; i++) begin
            exp[i] = expected_xlate(va[i], asid_a);
        end
        for (int i = 0; i <= 7; i++) begin
            @(negedge clk);
            clear_strobes();
            if (i < 7) begin
                lookup_ena = 1'b1;
                vaddr      = va[i];
            end
            #1;
            check_bit("lookup_valid", lookup_valid, i > 0);
            if (i > 0) begin
                check_result("result", result, exp[i-1]);
            end
        end
        @(negedge clk);
        #1;
        check_bit("lookup_valid idle", lookup_valid, 1'b0);
    endtask

    task automatic exceptions_interrupts();
        exc_update_t e;
        exc_update_t e2;
        logic [31:0] hi;
        write_reg(COMPARE, 32'h0);
        write_reg(CAUSE, 32'h0);
        write_reg(STATUS, 32'h0);
        hi = {19'(random_bits(19)), 5'h0, asid_a};
        write_reg(ENTRYHI, hi);
        e = '{exccode: EXC_TLBL, bd: 1'b1, epc: random_bits(32), badvaddr_ena: 1'b1,
              badvaddr: random_bits(32)};
        // Exception against a same-cycle EPC write
        write_reg(EPC, random_bits(32));
        exc     = e;
        exc_ena = 1'b1;
        read_check("epc after exception", EPC, e.epc);
        check_word("epc port", epc, e.epc);
        read_check("cause after exception", CAUSE, {e.bd, 24'h0, e.exccode, 2'b00});
        read_check("status after exception", STATUS, STATUS_RESET | 32'h2);
        read_check("badvaddr", BADVADDR, e.badvaddr);
        read_check("entryhi after tlb exception", ENTRYHI, {e.badvaddr[31:13], 5'h0, asid_a});
        e2 = '{exccode: 5'd8, bd: 1'b0, epc: random_bits(32), badvaddr_ena: 1'b0,
               badvaddr: random_bits(32)};
        @(negedge clk);
        clear_strobes();
        exc     = e2;
        exc_ena = 1'b1;
        read_check("epc after syscall", EPC, e2.epc);
        read_check("cause after syscall", CAUSE, {25'h0, e2.exccode, 2'b00});
        read_check("badvaddr kept", BADVADDR, e.badvaddr);
        read_check("entryhi kept", ENTRYHI, {e.badvaddr[31:13], 5'h0, asid_a});
        @(negedge clk);
        clear_strobes();
        eret = 1'b1;
        read_check("status after eret", STATUS, STATUS_RESET);
        write_reg(CAUSE, 32'h0000_0100);
        int_check(32'h0000_0001, 6'h00, 1'b0);
        int_check(32'h0000_0101, 6'h00, 1'b1);
        int_check(32'h0000_0103, 6'h00, 1'b0);
        int_check(32'h0000_0100, 6'h00, 1'b0);
        write_reg(CAUSE, 32'h0);
        int_check(32'h0000_1001, 6'b000100, 1'b1);
        int_check(32'h0000_8001, 6'b100000, 1'b1);
        int_check(32'h0000_8001, 6'b000000, 1'b0);
    endtask

    task automatic timer_interrupt();
        logic [31:0] c;
        logic [31:0] k;
        logic [31:0] rd;
        int          base;
        c = {1'b0, 31'(random_bits(31))};
        k = 32'd8 + 32'(random_bits(3));
        write_reg(STATUS, 32'h0000_8001);
        write_reg(COUNT, c);
        // Count is loaded at the coming edge
        base = cycles + 1;
        write_reg(COMPARE, c + k);
        repeat (3) begin
            @(negedge clk);
            clear_strobes();
        end
        read_reg(COUNT, rd);
        check_word("count", rd, c + 32'((cycles - base) / 2));
        while (cycles - base < 2 * k + 2 && !has_int) begin
            @(negedge clk);
            #1;
        end
        if (!has_int) begin
            errors++;
            $display("Timer interrupt did not arrive within %0d cycles", 2 * k + 2);
        end
        read_reg(CAUSE, rd);
        check_bit("cause ti", rd[CAUSE_TI], 1'b1);
        write_reg(COMPARE, c + k + 32'd1000);
        read_reg(CAUSE, rd);
        check_bit("cause ti cleared", rd[CAUSE_TI], 1'b0);
        @(negedge clk);
        clear_strobes();
        #1;
        check_bit("has_int after compare write", has_int, 1'b0);
    endtask

    initial begin
        rst       = 1'b1;
        errors    = 0;
        lfsr      = 32'ha595;
        mfc0_addr = INDEX;
        mtc0_addr = INDEX;
        mtc0_data = '0;
        exc       = '0;
        interrupt = '0;
        vaddr     = '0;
        clear_strobes();
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            model_tlb[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        #1;
        check_bit("lookup_valid after reset", lookup_valid, 1'b0);
        check_bit("has_int after reset", has_int, 1'b0);
        register_access();
        tlb_write_read();
        tlb_probe();
        translation();
        exceptions_interrupts();
        timer_interrupt();
        @(negedge clk);
        clear_strobes();
        errors += i_mmu_top.i_tlb_ctrl.i_mmu_assertions.assert_errors;
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sim/mmu_assertions.sv
module mmu_assertions #(
    parameter int TLB_ENTRIES = 16
) (
    input logic                   clk,
    input logic                   rst,
    input logic [TLB_ENTRIES-1:0] wr_en,
    input logic                   tlbp_done,
    input logic                   tlbr_done,
    input logic                   lookup_ena,
    input logic                   lookup_valid
);

    int assert_errors = 0;

    wr_en_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(wr_en))
        else begin
            assert_errors++;
            $error("wr_en selects more than one TLB slot");
        end

    ops_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(tlbp_done && tlbr_done))
        else begin
            assert_errors++;
            $error("tlbp_done and tlbr_done are high together");
        end

    // One registered stage between lookup and result
    valid_follows: assert property (@(posedge clk) disable iff (rst)
        lookup_ena |=> lookup_valid)
        else begin
            assert_errors++;
            $error("lookup_valid missing one cycle after lookup_ena");
        end

    valid_only_after_ena: assert property (@(posedge clk) disable iff (rst)
        !lookup_ena |=> !lookup_valid)
        else begin
            assert_errors++;
            $error("lookup_valid high without a lookup in the cycle before");
        end

endmodule

bind tlb_ctrl mmu_assertions #(.TLB_ENTRIES(TLB_ENTRIES)) i_mmu_assertions (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (wr_en),
    .tlbp_done    (tlbp_done),
    .tlbr_done    (tlbr_done),
    .lookup_ena   (lookup_ena),
    .lookup_valid (xlate_valid_q)
);

//--- hw/mmu_top.sv
module mmu_top import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          mfc0_ena,
    input  cp0_reg_e      mfc0_addr,
    output logic [31:0]   mfc0_data,
    input  logic          mtc0_ena,
    input  cp0_reg_e      mtc0_addr,
    input  logic [31:0]   mtc0_data,
    input  logic          exc_ena,
    input  exc_update_t   exc,
    input  logic          eret,
    input  logic [5:0]    interrupt,
    output logic          has_int,
    input  tlb_op_e       tlb_op,
    input  logic          lookup_ena,
    input  logic [31:0]   vaddr,
    output logic          lookup_valid,
    output xlate_result_t result,
    output logic [31:0]   epc
);

    logic [31:0]                  index;
    logic [31:0]                  entryhi;
    logic [31:0]                  entrylo0;
    logic [31:0]                  entrylo1;
    logic [TLB_ENTRIES-1:0]       wr_en;
    tlb_entry_t                   wr_entry;
    tlb_key_t                     probe_key;
    tlb_key_t                     xlate_key;
    logic                         xlate_odd;
    logic [11:0]                  xlate_offset;
    logic                         xlate_valid_q;
    logic                         tlbp_done;
    logic                         tlbr_done;
    tlb_entry_t [TLB_ENTRIES-1:0] entries;
    logic [TLB_ENTRIES-1:0]       probe_hits;
    logic [TLB_ENTRIES-1:0]       xlate_hits;
    logic [IDX_W-1:0]             probe_index;
    logic                         probe_miss;
    tlb_entry_t                   rd_entry;

    cp0 #(.TLB_ENTRIES(TLB_ENTRIES)) i_cp0 (
        .clk, .rst, .interrupt,
        .mfc0_ena, .mfc0_addr, .mfc0_data,
        .mtc0_ena, .mtc0_addr, .mtc0_data,
        .exc_ena, .exc, .eret,
        .tlbp_done, .probe_index, .probe_miss, .tlbr_done, .rd_entry,
        .has_int, .epc, .index, .entryhi, .entrylo0, .entrylo1
    );

    tlb_ctrl #(.TLB_ENTRIES(TLB_ENTRIES)) i_tlb_ctrl (
        .clk, .rst, .tlb_op, .lookup_ena, .vaddr,
        .index, .entryhi, .entrylo0, .entrylo1,
        .wr_en, .wr_entry, .probe_key, .xlate_key,
        .xlate_odd, .xlate_offset, .xlate_valid_q, .tlbp_done, .tlbr_done
    );

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_slot
        tlb_entry i_tlb_entry (
            .clk       (clk),
            .rst       (rst),
            .wr_en     (wr_en[i]),
            .wr_entry  (wr_entry),
            .probe_key (probe_key),
            .xlate_key (xlate_key),
            .entry     (entries[i]),
            .probe_hit (probe_hits[i]),
            .xlate_hit (xlate_hits[i])
        );
    end

    tlb_match_sel #(.TLB_ENTRIES(TLB_ENTRIES)) i_tlb_match_sel (
        .entries, .probe_hits, .xlate_hits, .index,
        .xlate_odd, .xlate_offset, .xlate_valid_q,
        .probe_index, .probe_miss, .rd_entry, .lookup_valid, .result
    );

endmodule

//--- hw/tlb_match_sel.sv
module tlb_match_sel import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1
) (
    input  tlb_entry_t [TLB_ENTRIES-1:0] entries,
    input  logic [TLB_ENTRIES-1:0]       probe_hits,
    input  logic [TLB_ENTRIES-1:0]       xlate_hits,
    input  logic [31:0]                  index,
    input  logic                         xlate_odd,
    input  logic [11:0]                  xlate_offset,
    input  logic                         xlate_valid_q,
    output logic [IDX_W-1:0]             probe_index,
    output logic                         probe_miss,
    output tlb_entry_t                   rd_entry,
    output logic                         lookup_valid,
    output xlate_result_t                result
);

    logic [IDX_W-1:0] xlate_index;
    tlb_entry_t       hit_entry;

    // Lowest-numbered set bit wins
    function automatic logic [IDX_W-1:0] lowest_hit(logic [TLB_ENTRIES-1:0] hits);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    assign probe_index = lowest_hit(probe_hits);
    assign probe_miss  = ~|probe_hits;
    assign rd_entry    = entries[index[IDX_W-1:0]];

    assign xlate_index  = lowest_hit(xlate_hits);
    assign hit_entry    = entries[xlate_index];
    assign lookup_valid = xlate_valid_q;

    always_comb begin
        result.miss = ~|xlate_hits;
        if (xlate_odd) begin
            result.paddr   = {hit_entry.pfn1, xlate_offset};
            result.invalid = ~result.miss & ~hit_entry.v1;
            result.dirty   = hit_entry.d1;
            result.cache   = hit_entry.c1;
        end else begin
            result.paddr   = {hit_entry.pfn0, xlate_offset};
            result.invalid = ~result.miss & ~hit_entry.v0;
            result.dirty   = hit_entry.d0;
            result.cache   = hit_entry.c0;
        end
    end

endmodule

//--- hw/tlb_ctrl.sv
module tlb_ctrl import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  tlb_op_e                tlb_op,
    input  logic                   lookup_ena,
    input  logic [31:0]            vaddr,
    input  logic [31:0]            index,
    input  logic [31:0]            entryhi,
    input  logic [31:0]            entrylo0,
    input  logic [31:0]            entrylo1,
    output logic [TLB_ENTRIES-1:0] wr_en,
    output tlb_entry_t             wr_entry,
    output tlb_key_t               probe_key,
    output tlb_key_t               xlate_key,
    output logic                   xlate_odd,
    output logic [11:0]            xlate_offset,
    output logic                   xlate_valid_q,
    output logic                   tlbp_done,
    output logic                   tlbr_done
);

    logic [31:0] vaddr_q;

    // EntryLo layout is PFN 25:6, C 5:3, D 2, V 1, G 0
    always_comb begin
        wr_entry.vpn2 = entryhi[31:13];
        wr_entry.asid = entryhi[7:0];
        wr_entry.g    = entrylo0[0] & entrylo1[0];
        wr_entry.pfn0 = entrylo0[25:6];
        wr_entry.c0   = entrylo0[5:3];
        wr_entry.d0   = entrylo0[2];
        wr_entry.v0   = entrylo0[1];
        wr_entry.pfn1 = entrylo1[25:6];
        wr_entry.c1   = entrylo1[5:3];
        wr_entry.d1   = entrylo1[2];
        wr_entry.v1   = entrylo1[1];
    end

    always_comb begin
        wr_en = '0;
        if (tlb_op == TLB_WI) begin
            wr_en[index[IDX_W-1:0]] = 1'b1;
        end
    end

    assign tlbp_done = (tlb_op == TLB_P);
    assign tlbr_done = (tlb_op == TLB_R);

    // Translation stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            xlate_valid_q <= 1'b0;
        end else begin
            xlate_valid_q <= lookup_ena;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_ena) begin
            vaddr_q <= vaddr;
        end
    end

    assign xlate_odd    = vaddr_q[12];
    assign xlate_offset = vaddr_q[11:0];

    assign probe_key.vpn2 = entryhi[31:13];
    assign probe_key.asid = entryhi[7:0];
    assign xlate_key.vpn2 = vaddr_q[31:13];
    assign xlate_key.asid = entryhi[7:0];

endmodule

//--- hw/tlb_entry.sv
module tlb_entry import mmu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  tlb_entry_t wr_entry,
    input  tlb_key_t   probe_key,
    input  tlb_key_t   xlate_key,
    output tlb_entry_t entry,
    output logic       probe_hit,
    output logic       xlate_hit
);

    tlb_entry_t entry_q;

    // Global entries ignore the ASID
    function automatic logic key_hit(tlb_entry_t e, tlb_key_t key);
        logic vpn_eq;
        logic asid_eq;
        vpn_eq  = (e.vpn2 == key.vpn2);
        asid_eq = (e.asid == key.asid);
        return vpn_eq && (e.g || asid_eq);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_q <= '0;
        end else if (wr_en) begin
            entry_q <= wr_entry;
        end
    end

    assign entry     = entry_q;
    assign probe_hit = key_hit(entry_q, probe_key);
    assign xlate_hit = key_hit(entry_q, xlate_key);

endmodule

//--- hw/cp0.sv
module cp0 import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [5:0]       interrupt,

    input  logic             mfc0_ena,
    input  cp0_reg_e         mfc0_addr,
    output logic [31:0]      mfc0_data,

    input  logic             mtc0_ena,
    input  cp0_reg_e         mtc0_addr,
    input  logic [31:0]      mtc0_data,

    input  logic             exc_ena,
    input  exc_update_t      exc,
    input  logic             eret,

    input  logic             tlbp_done,
    input  logic [IDX_W-1:0] probe_index,
    input  logic             probe_miss,
    input  logic             tlbr_done,
    input  tlb_entry_t       rd_entry,

    output logic             has_int,
    output logic [31:0]      epc,
    output logic [31:0]      index,
    output logic [31:0]      entryhi,
    output logic [31:0]      entrylo0,
    output logic [31:0]      entrylo1
);

    // MMU size field reflects the actual TLB depth
    localparam logic [31:0] CONFIG1_VAL = {CONFIG1_RESET[31], 6'(TLB_ENTRIES - 1),
                                           CONFIG1_RESET[24:0]};

    logic [31:0] index_q;
    logic [31:0] entryhi_q;
    logic [31:0] entrylo0_q;
    logic [31:0] entrylo1_q;
    logic [31:0] badvaddr_q;
    logic [32:0] count_q;
    logic [31:0] compare_q;
    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;
    logic [31:0] config_q;
    logic        exc_is_tlb;

    assign exc_is_tlb = (exc.exccode == EXC_MOD) || (exc.exccode == EXC_TLBL) ||
                        (exc.exccode == EXC_TLBS);

    assign epc      = epc_q;
    assign index    = index_q;
    assign entryhi  = entryhi_q;
    assign entrylo0 = entrylo0_q;
    assign entrylo1 = entrylo1_q;

    assign has_int = (|(cause_q[15:8] & status_q[15:8])) & status_q[STATUS_IE] &
                     ~status_q[STATUS_EXL];

    always_ff @(posedge clk) begin
        if (rst) begin
            index_q   <= '0;
            entryhi_q <= '0;
            count_q   <= '0;
            compare_q <= '0;
            status_q  <= STATUS_RESET;
            cause_q   <= '0;
            config_q  <= CONFIG_RESET;
        end else begin
            count_q        <= count_q + 33'd1;
            // IP7 shares the timer with hardware line 5
            cause_q[15:10] <= {cause_q[CAUSE_TI] | interrupt[5], interrupt[4:0]};

            if (compare_q != '0 && count_q[32:1] == compare_q) begin
                cause_q[CAUSE_TI] <= 1'b1;
            end

            if (eret) begin
                status_q[STATUS_EXL] <= 1'b0;
            end

            if (mtc0_ena) begin
                case (mtc0_addr)
                    INDEX:   index_q <= 32'(mtc0_data[IDX_W-1:0]);
                    ENTRYHI: entryhi_q <= {mtc0_data[31:13], 5'h0, mtc0_data[7:0]};
                    COUNT:   count_q <= {mtc0_data, 1'b0};
                    COMPARE: begin
                        compare_q         <= mtc0_data;
                        cause_q[CAUSE_TI] <= 1'b0;
                    end
                    STATUS: begin
                        status_q[15:8]       <= mtc0_data[15:8];
                        status_q[STATUS_EXL] <= mtc0_data[STATUS_EXL];
                        status_q[STATUS_IE]  <= mtc0_data[STATUS_IE];
                    end
                    CAUSE:   cause_q[9:8] <= mtc0_data[9:8];
                    CONFIG:  config_q[2:0] <= mtc0_data[2:0];
                    default: ;
                endcase
            end

            if (tlbp_done) begin
                index_q <= probe_miss ? 32'h8000_0000 : 32'(probe_index);
            end

            if (tlbr_done) begin
                entryhi_q <= {rd_entry.vpn2, 5'h0, rd_entry.asid};
            end

            if (exc_ena) begin
                cause_q[6:2]         <= exc.exccode;
                cause_q[CAUSE_BD]    <= exc.bd;
                status_q[STATUS_EXL] <= 1'b1;
                if (exc_is_tlb) begin
                    entryhi_q[31:13] <= exc.badvaddr[31:13];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mtc0_ena && mtc0_addr == ENTRYLO0) begin
            entrylo0_q <= {6'h0, mtc0_data[25:0]};
        end
        if (mtc0_ena && mtc0_addr == ENTRYLO1) begin
            entrylo1_q <= {6'h0, mtc0_data[25:0]};
        end
        if (tlbr_done) begin
            entrylo0_q <= {6'h0, rd_entry.pfn0, rd_entry.c0, rd_entry.d0, rd_entry.v0,
                           rd_entry.g};
            entrylo1_q <= {6'h0, rd_entry.pfn1, rd_entry.c1, rd_entry.d1, rd_entry.v1,
                           rd_entry.g};
        end
        if (mtc0_ena && mtc0_addr == EPC) begin
            epc_q <= mtc0_data;
        end
        if (exc_ena) begin
            epc_q <= exc.epc;
            if (exc.badvaddr_ena) begin
                badvaddr_q <= exc.badvaddr;
            end
        end
    end

    always_comb begin
        mfc0_data = '0;
        if (mfc0_ena) begin
            if (mtc0_ena && mtc0_addr == mfc0_addr) begin
                mfc0_data = mtc0_data;
            end else begin
                case (mfc0_addr)
                    INDEX:    mfc0_data = index_q;
                    ENTRYLO0: mfc0_data = entrylo0_q;
                    ENTRYLO1: mfc0_data = entrylo1_q;
                    BADVADDR: mfc0_data = badvaddr_q;
                    COUNT:    mfc0_data = count_q[32:1];
                    ENTRYHI:  mfc0_data = entryhi_q;
                    COMPARE:  mfc0_data = compare_q;
                    STATUS:   mfc0_data = status_q;
                    CAUSE:    mfc0_data = cause_q;
                    EPC:      mfc0_data = epc_q;
                    CONFIG:   mfc0_data = config_q;
                    CONFIG1:  mfc0_data = CONFIG1_VAL;
                    default:  mfc0_data = '0;
                endcase
            end
        end
    end

endmodule

//--- hw/mmu_pkg.sv
package mmu_pkg;

    // CP0 register addresses as {register number, select}
    typedef enum logic [7:0] {
        INDEX    = {5'd0, 3'd0},
        ENTRYLO0 = {5'd2, 3'd0},
        ENTRYLO1 = {5'd3, 3'd0},
        BADVADDR = {5'd8, 3'd0},
        COUNT    = {5'd9, 3'd0},
        ENTRYHI  = {5'd10, 3'd0},
        COMPARE  = {5'd11, 3'd0},
        STATUS   = {5'd12, 3'd0},
        CAUSE    = {5'd13, 3'd0},
        EPC      = {5'd14, 3'd0},
        CONFIG   = {5'd16, 3'd0},
        CONFIG1  = {5'd16, 3'd1}
    } cp0_reg_e;

    typedef enum logic [1:0] {
        TLB_NONE,
        TLB_P,
        TLB_R,
        TLB_WI
    } tlb_op_e;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    // Lookup key made of VPN2 and address space
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
    } tlb_key_t;

    typedef struct packed {
        logic [4:0]  exccode;
        logic        bd;
        logic [31:0] epc;
        logic        badvaddr_ena;
        logic [31:0] badvaddr;
    } exc_update_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        miss;
        logic        invalid;
        logic        dirty;
        logic [2:0]  cache;
    } xlate_result_t;

    localparam int STATUS_IE  = 0;
    localparam int STATUS_EXL = 1;
    localparam int CAUSE_TI   = 30;
    localparam int CAUSE_BD   = 31;

    // TLB related exception codes
    localparam logic [4:0] EXC_MOD  = 5'd1;
    localparam logic [4:0] EXC_TLBL = 5'd2;
    localparam logic [4:0] EXC_TLBS = 5'd3;

    localparam logic [31:0] STATUS_RESET  = 32'h0040_0000;
    // M set, standard TLB, kseg0 cached
    localparam logic [31:0] CONFIG_RESET  = 32'h8000_0083;
    // 16 entries, 2-way 256-set 16B-line caches
    localparam logic [31:0] CONFIG1_RESET = {1'b0, 6'd15, 3'd2, 3'd3, 3'd1,
                                             3'd2, 3'd3, 3'd1, 7'd0};

endpackage
